/* files.f */
r24_pkg.sv
led_ddac.sv
panel_io_word.sv
usb_route.sv
r24_ctrl_regs.sv
r24_top.sv
r24_properties.sv
tb_r24_top.sv

/* Makefile */
# Verilator flow for the r24 register core

TOP             ?= tb_r24_top
LINT_TOP        ?= r24_top
FILELIST        ?= files.f
VERILATOR       ?= verilator
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS      ?= --lint-only -Wall --timing
PASS_MSG        ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

# Pass or fail comes from the simulator output, not its exit code
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tb_r24_top.sv */
`timescale 1ns/1ps

module tb_r24_top;
    import r24_pkg::*;

    localparam time         CLK_PERIOD   = 40ns;
    localparam int          RESET_CYCLES = 10;
    localparam int unsigned SEED         = 32'hf8892e84;
    localparam int          N_REG        = 16;   // Readback writes
    localparam int          N_USB        = 8;    // USB pushes and pops
    localparam int          N_MODE       = 64;   // Cycles per router mode
    localparam int          N_PANEL      = 16;
    localparam int          N_LED        = 4;    // Brightness windows
    // An APB access costs 3 cycles, an LED window about 270
    localparam int  TEST_CYCLES = RESET_CYCLES + 40 + N_REG * 6 + 24 + N_USB * 11 +
                                  3 * (N_MODE + 8) + N_PANEL * 5 + N_LED * 270;
    localparam time TIMEOUT     = 2 * TEST_CYCLES * CLK_PERIOD;

    localparam usb_rd_t RD_IDLE = '{data: '0, be: '0, valid: 1'b0, empty: 1'b1};

    logic                 clk = 1'b0;
    logic                 reset;
    apb_req_t             apb;
    usb_rd_t              usb_rd;
    logic                 usb_wr_full;
    logic [ADC_W-1:0]     adc_a_data;
    logic                 adc_a_dor;
    logic                 adc_b_dor;
    logic [DATA_W-1:0]    prdata;
    usb_wr_t              usb_wr;
    logic                 usb_rd_en;
    panel_word_t          panel_word;
    logic                 led0;
    logic                 led1;

    // Expectations, set on falling edges
    string                tag = "";
    logic                 chk_prdata = 1'b0;
    logic [DATA_W-1:0]    exp_prdata = '0;
    logic                 chk_usb = 1'b0;     // usb_wr and usb_rd_en
    logic                 chk_rden = 1'b0;    // usb_rd_en only
    usb_wr_t              exp_usb_wr = '0;
    logic                 exp_rd_en = 1'b0;
    logic                 chk_panel = 1'b0;
    panel_word_t          exp_panel = '0;
    logic                 count_clr = 1'b0;
    logic                 count_en = 1'b0;
    logic                 count_chk = 1'b0;
    int                   exp_led0_count = 0;
    int                   exp_led1_count = 0;
    int                   led0_count = 0;
    int                   led1_count = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    r24_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .apb         (apb),
        .usb_rd      (usb_rd),
        .usb_wr_full (usb_wr_full),
        .adc_a_data  (adc_a_data),
        .adc_a_dor   (adc_a_dor),
        .adc_b_dor   (adc_b_dor),
        .prdata      (prdata),
        .usb_wr      (usb_wr),
        .usb_rd_en   (usb_rd_en),
        .panel_word  (panel_word),
        .led0        (led0),
        .led1        (led1)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Expander bits one by one, LEDs active low
    function automatic panel_word_t panel_model(input panel_ch_t a, input panel_ch_t b,
                                                input logic dor_a, input logic dor_b);
        panel_word_t w;
        w = '0;                               // Unused bits and LED commons
        w.port0[6] = a.amp_en;
        w.port0[5] = ~a.att[1];
        w.port0[4] = ~a.att[0];
        w.port0[2] = b.amp_en;
        w.port0[1] = ~b.att[1];
        w.port0[0] = ~b.att[0];
        w.port1[6] = ~(a.led[2] | dor_a);     // Red A, lit on overrange
        w.port1[5] = ~(b.led[2] | dor_b);     // Red B
        w.port1[3] = ~(b.led[1] & ~dor_b);    // Green B
        w.port1[2] = ~(b.led[0] & ~dor_b);    // Blue B
        w.port1[1] = ~(a.led[1] & ~dor_a);
        w.port1[0] = ~(a.led[0] & ~dor_a);
        return w;
    endfunction

    function automatic usb_wr_t route_wr_model(input usb_mode_t mode, input usb_wr_t raw,
                                               input logic [ADC_W-1:0] adc, input usb_rd_t rd);
        usb_wr_t w;
        case (mode)
            MODE_REGS: w = raw;
            MODE_IDLE: w = '{data: '0, be: '1, valid: 1'b0};
            MODE_ADC:  w = '{data: {{(USB_DATA_W - ADC_W){1'b0}}, adc}, be: '1, valid: 1'b1};
            default:   w = '{data: rd.data, be: rd.be, valid: rd.valid}; // Loopback
        endcase
        return w;
    endfunction

    function automatic logic route_rd_en_model(input usb_mode_t mode, input logic raw_rd_en,
                                               input logic full);
        case (mode)
            MODE_REGS: return raw_rd_en;
            MODE_IDLE: return 1'b0;
            MODE_ADC:  return 1'b1;           // Stream without stopping
            default:   return ~full;
        endcase
    endfunction

    // Pulses in 256 cycles
    function automatic int led_pulses(input logic [LED_DEPTH-1:0] level);
        return int'(level) / 256;
    endfunction

    function automatic logic [ADDR_W-1:0] reg_addr(input logic [OFFS_W-1:0] offs);
        return {APB_BASE_PAGE, REGION_REGS, offs};
    endfunction

    function automatic usb_rd_t rand_usb_rd();
        logic [63:0] bits;
        bits = {$urandom(), $urandom()};
        return bits[$bits(usb_rd_t)-1:0];
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %b expected %b",
                                $time, what, got, exp));
    endtask

    task automatic check_usb_wr(input usb_wr_t got, input usb_wr_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %h/%h/%b expected %h/%h/%b",
                                $time, what, got.data, got.be, got.valid,
                                exp.data, exp.be, exp.valid));
    endtask

    task automatic check_panel(input panel_word_t got, input panel_word_t exp,
                               input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %h_%h expected %h_%h",
                                $time, what, got.port1, got.port0, exp.port1, exp.port0));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            abort_run($sformatf("mismatch at %0t: %s got %0d pulses expected %0d",
                                $time, what, got, exp));
    endtask

    // Samples before the rising edge takes effect
    always @(posedge clk) begin
        if (chk_prdata)
            check_word(prdata, exp_prdata, {tag, " prdata"});
        if (chk_usb)
            check_usb_wr(usb_wr, exp_usb_wr, {tag, " usb_wr"});
        if (chk_usb || chk_rden)
            check_bit(usb_rd_en, exp_rd_en, {tag, " usb_rd_en"});
        if (chk_panel)
            check_panel(panel_word, exp_panel, {tag, " panel_word"});
        if (count_clr) begin
            led0_count = 0;
            led1_count = 0;
        end else if (count_en) begin
            led0_count = led0_count + int'(led0);
            led1_count = led1_count + int'(led1);
        end
        if (count_chk) begin
            check_count(led0_count, exp_led0_count, {tag, " led0"});
            check_count(led1_count, exp_led1_count, {tag, " led1"});
        end
        if (dut_i.props_i.fail_count != 0)
            abort_run("a bound assertion on the DUT failed");
    end

    //////////////////////////////////////////////////
    // APB master
    //////////////////////////////////////////////////

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(negedge clk);
        apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(negedge clk);
        apb.penable = 1'b1;                   // Access cycle
        @(negedge clk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    // rd_pop also checks usb_rd_en in setup and access
    task automatic apb_read_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp,
                                  input logic rd_pop, input string what);
        @(negedge clk);
        apb       = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        tag       = what;
        exp_rd_en = 1'b0;
        chk_rden  = rd_pop;
        @(negedge clk);
        apb.penable = 1'b1;
        exp_prdata  = exp;
        chk_prdata  = 1'b1;
        exp_rd_en   = rd_pop;
        @(negedge clk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
        chk_prdata  = 1'b0;
        chk_rden    = 1'b0;
        exp_rd_en   = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic reset_state();
        tag       = "after reset";
        exp_panel = panel_model('0, '0, 1'b0, 1'b0);
        chk_panel = 1'b1;
        exp_rd_en = 1'b0;
        chk_rden  = 1'b1;
        @(negedge clk);
        chk_panel = 1'b0;
        chk_rden  = 1'b0;
        apb_read_check(reg_addr(REG_CTRL), 32'(MODE_REGS), 1'b0, "mode after reset");
        apb_read_check(reg_addr(REG_LED0), '0, 1'b0, "led0 after reset");
        apb_read_check(reg_addr(REG_PANEL), '0, 1'b0, "panel after reset");
    endtask

    task automatic regs_readback();
        logic [OFFS_W-1:0] offs;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] mask;               // Implemented bits
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < N_REG; i++) begin
            case ($urandom_range(4, 0))
                0: begin
                    offs = REG_CTRL;
                    mask = 32'h0000_0003;
                end
                1: begin
                    offs = REG_LED0;
                    mask = 32'h0000_ffff;
                end
                2: begin
                    offs = REG_LED1;
                    mask = 32'h0000_ffff;
                end
                3: begin
                    offs = REG_USB_WR_BE;
                    mask = 32'h0000_000f;
                end
                default: begin
                    offs = REG_PANEL;
                    mask = 32'h0000_3f3f;
                end
            endcase
            data = $urandom();
            apb_write(reg_addr(offs), data);
            apb_read_check(reg_addr(offs), data & mask, 1'b0, "register readback");
        end
        apb_write(reg_addr(REG_LED0), 32'h0000_ffff); // Nonzero behind foreign reads
        for (int i = 0; i < 8; i++) begin
            addr = reg_addr(REG_LED0);
            if (i % 2 == 0) begin
                addr[15:12] = 4'($urandom());
                if (addr[15:12] == REGION_REGS)
                    addr[15:12] = REGION_REGS + 4'd1;
            end else begin
                addr[31:16] = 16'($urandom());
                if (addr[31:16] == APB_BASE_PAGE)
                    addr[16] = ~addr[16];
            end
            apb_read_check(addr, '0, 1'b0, "foreign region or page");
        end
        apb_write(reg_addr(REG_CTRL), 32'(MODE_REGS));
    endtask

    task automatic usb_reg_access();
        logic [USB_BE_W-1:0]   be;
        logic [USB_DATA_W-1:0] data;
        logic [USB_DATA_W-1:0] last;           // Previous payload still on the bus
        be   = 4'($urandom());
        last = $urandom();
        apb_write(reg_addr(REG_USB_WR_BE), 32'(be));
        apb_write(reg_addr(REG_USB_WR_DATA), last);
        @(negedge clk);                        // Priming push goes by
        for (int i = 0; i < N_USB; i++) begin
            data       = $urandom();
            tag        = "usb register write";
            exp_rd_en  = 1'b0;
            exp_usb_wr = '{data: last, be: be, valid: 1'b0};
            chk_usb    = 1'b1;
            apb_write(reg_addr(REG_USB_WR_DATA), data);
            exp_usb_wr = '{data: data, be: be, valid: 1'b1}; // Strobe cycle
            @(negedge clk);
            exp_usb_wr.valid = 1'b0;
            @(negedge clk);
            chk_usb = 1'b0;
            last    = data;
        end
        for (int i = 0; i < N_USB; i++) begin
            usb_rd      = rand_usb_rd();
            usb_wr_full = 1'($urandom());
            apb_read_check(reg_addr(REG_USB_RD_DATA), usb_rd.data, 1'b1, "usb read data");
            apb_read_check(reg_addr(REG_STATUS), {30'b0, usb_rd.empty, usb_wr_full}, 1'b0,
                           "status");
        end
        usb_rd      = RD_IDLE;
        usb_wr_full = 1'b0;
    endtask

    task automatic route_mode(input usb_mode_t mode);
        apb_write(reg_addr(REG_CTRL), 32'(mode));
        tag = {"router ", mode.name()};
        for (int i = 0; i < N_MODE; i++) begin
            adc_a_data  = 8'($urandom());
            usb_rd      = rand_usb_rd();
            usb_wr_full = 1'($urandom());
            exp_usb_wr  = route_wr_model(mode, '0, adc_a_data, usb_rd);
            exp_rd_en   = route_rd_en_model(mode, 1'b0, usb_wr_full);
            chk_usb     = 1'b1;
            @(negedge clk);
        end
        chk_usb     = 1'b0;
        usb_rd      = RD_IDLE;
        usb_wr_full = 1'b0;
        apb_write(reg_addr(REG_CTRL), 32'(MODE_REGS));
    endtask

    task automatic panel_packing();
        panel_ch_t a;
        panel_ch_t b;
        for (int i = 0; i < N_PANEL; i++) begin
            a = 6'($urandom());
            b = 6'($urandom());
            apb_write(reg_addr(REG_PANEL), {18'b0, b, 2'b0, a});
            adc_a_dor = i[0];                 // All four overrange combinations
            adc_b_dor = i[1];
            @(negedge clk);
            tag       = "panel word";
            exp_panel = panel_model(a, b, adc_a_dor, adc_b_dor);
            chk_panel = 1'b1;
            @(negedge clk);
            chk_panel = 1'b0;
        end
        adc_a_dor = 1'b0;
        adc_b_dor = 1'b0;
    endtask

    task automatic led_brightness();
        logic [LED_DEPTH-1:0] lvl0;
        logic [LED_DEPTH-1:0] lvl1;
        for (int i = 0; i < N_LED; i++) begin
            lvl0 = (i == 0) ? 16'h0000 : {8'($urandom()), 8'h00}; // Dark first
            lvl1 = (i == 1) ? 16'hff00 : {8'($urandom()), 8'h00}; // Brightest step
            apb_write(reg_addr(REG_LED0), 32'(lvl0));
            apb_write(reg_addr(REG_LED1), 32'(lvl1));
            exp_led0_count = led_pulses(lvl0);
            exp_led1_count = led_pulses(lvl1);
            count_clr = 1'b1;
            @(negedge clk);
            count_clr = 1'b0;
            count_en  = 1'b1;
            repeat (256) @(negedge clk);
            count_en  = 1'b0;
            tag       = "led brightness";
            count_chk = 1'b1;
            @(negedge clk);
            count_chk = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset       = 1'b1;
        apb         = '0;
        usb_rd      = RD_IDLE;
        usb_wr_full = 1'b0;
        adc_a_data  = '0;
        adc_a_dor   = 1'b0;
        adc_b_dor   = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        reset_state();
        regs_readback();
        usb_reg_access();
        route_mode(MODE_IDLE);
        route_mode(MODE_ADC);
        route_mode(MODE_LOOP);
        panel_packing();
        led_brightness();
        @(negedge clk);
        if (dut_i.props_i.fail_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run("a bound assertion on the DUT failed");
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        abort_run($sformatf("timeout at %0t, the run did not complete", $time));
    end

endmodule

/* r24_properties.sv */
`timescale 1ns/1ps

module r24_properties (
    input logic               clk,
    input logic               reset,
    input r24_pkg::apb_req_t  apb,
    input r24_pkg::usb_mode_t usb_mode,
    input r24_pkg::usb_wr_t   usb_wr,
    input logic               usb_rd_en,
    input logic               usb_wr_full
);
    import r24_pkg::*;

    int   fail_count = 0;  // Failed assertions so far
    logic apb_access;
    logic apb_seen;        // Any access since reset

    assign apb_access = apb.psel && apb.penable;

    always_ff @(posedge clk) begin
        if (reset)
            apb_seen <= 1'b0;
        else if (apb_access)
            apb_seen <= 1'b1;
    end

    // USB side stays quiet until software touches the bus
    quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        (!apb_seen && !apb_access) |-> (!usb_wr.valid && !usb_rd_en))
        else begin
            fail_count++;
            $error("USB activity before any APB access");
        end

    // Full write FIFO stops the loopback reads
    loop_full_stall: assert property (@(posedge clk) disable iff (reset)
        (usb_mode == MODE_LOOP && usb_wr_full) |-> !usb_rd_en)
        else begin
            fail_count++;
            $error("loopback read while the write FIFO is full");
        end

    regs_single_push: assert property (@(posedge clk) disable iff (reset)
        (usb_mode == MODE_REGS && usb_wr.valid) |=> (usb_mode != MODE_REGS || !usb_wr.valid))
        else begin
            fail_count++;
            $error("register-driven USB push longer than one cycle");
        end

endmodule

bind r24_top r24_properties props_i (
    .clk         (clk),
    .reset       (reset),
    .apb         (apb),
    .usb_mode    (usb_mode),
    .usb_wr      (usb_wr),
    .usb_rd_en   (usb_rd_en),
    .usb_wr_full (usb_wr_full)
);

/* r24_top.sv */
`timescale 1ns/1ps

module r24_top (
    input  logic                        clk,
    input  logic                        reset,
    input  r24_pkg::apb_req_t           apb,
    input  r24_pkg::usb_rd_t            usb_rd,
    input  logic                        usb_wr_full,
    input  logic [r24_pkg::ADC_W-1:0]   adc_a_data,
    input  logic                        adc_a_dor,
    input  logic                        adc_b_dor,
    output logic [r24_pkg::DATA_W-1:0]  prdata,
    output r24_pkg::usb_wr_t            usb_wr,
    output logic                        usb_rd_en,
    output r24_pkg::panel_word_t        panel_word,
    output logic                        led0,
    output logic                        led1
);
    import r24_pkg::*;

    usb_mode_t              usb_mode;
    usb_wr_t                raw_wr;      // APB-driven write channel
    logic                   raw_rd_en;
    panel_ch_t              panel_a;
    panel_ch_t              panel_b;
    logic [LED_DEPTH-1:0]   led0_level;
    logic [LED_DEPTH-1:0]   led1_level;

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    r24_ctrl_regs regs_i (
        .clk         (clk),
        .reset       (reset),
        .apb         (apb),
        .usb_rd      (usb_rd),
        .usb_wr_full (usb_wr_full),
        .prdata      (prdata),
        .usb_mode    (usb_mode),
        .raw_wr      (raw_wr),
        .raw_rd_en   (raw_rd_en),
        .panel_a     (panel_a),
        .panel_b     (panel_b),
        .led0_level  (led0_level),
        .led1_level  (led1_level)
    );

    //////////////////////////////////////////////////
    // USB write path
    //////////////////////////////////////////////////

    usb_route route_i (
        .usb_mode    (usb_mode),
        .raw_wr      (raw_wr),
        .raw_rd_en   (raw_rd_en),
        .adc_a_data  (adc_a_data),
        .usb_rd      (usb_rd),
        .usb_wr_full (usb_wr_full),
        .usb_wr      (usb_wr),
        .usb_rd_en   (usb_rd_en)
    );

    // Front panel expander word, leaves at a port
    panel_io_word panel_i (
        .clk        (clk),
        .reset      (reset),
        .panel_a    (panel_a),
        .panel_b    (panel_b),
        .adc_a_dor  (adc_a_dor),
        .adc_b_dor  (adc_b_dor),
        .panel_word (panel_word)
    );

    //////////////////////////////////////////////////
    // Board LEDs
    //////////////////////////////////////////////////

    led_ddac #(.DEPTH(LED_DEPTH)) led0_ddac (
        .clk   (clk),
        .reset (reset),
        .level (led0_level),
        .out   (led0)
    );

    led_ddac #(.DEPTH(LED_DEPTH)) led1_ddac (
        .clk   (clk),
        .reset (reset),
        .level (led1_level),
        .out   (led1)
    );

endmodule

/* r24_ctrl_regs.sv */
`timescale 1ns/1ps

module r24_ctrl_regs (
    input  logic                            clk,
    input  logic                            reset,
    input  r24_pkg::apb_req_t               apb,
    input  r24_pkg::usb_rd_t                usb_rd,
    input  logic                            usb_wr_full,
    output logic [r24_pkg::DATA_W-1:0]      prdata,
    output r24_pkg::usb_mode_t              usb_mode,
    output r24_pkg::usb_wr_t                raw_wr,
    output logic                            raw_rd_en,
    output r24_pkg::panel_ch_t              panel_a,
    output r24_pkg::panel_ch_t              panel_b,
    output logic [r24_pkg::LED_DEPTH-1:0]   led0_level,
    output logic [r24_pkg::LED_DEPTH-1:0]   led1_level
);
    import r24_pkg::*;

    logic                  hit;        // Page and region match
    logic [OFFS_W-1:0]     offs;
    logic                  access;     // APB access phase
    logic                  wr_access;
    logic [USB_DATA_W-1:0] wr_data_q;
    logic [USB_BE_W-1:0]   wr_be_q;
    logic                  wr_stb_q;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    assign hit = (apb.paddr[ADDR_W-1:16] == APB_BASE_PAGE) &&
                 (apb.paddr[15:12] == REGION_REGS);
    assign offs      = apb.paddr[OFFS_W-1:0];
    assign access    = apb.psel && apb.penable && hit; // pready is always high
    assign wr_access = access && apb.pwrite;

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            usb_mode   <= MODE_REGS;
            led0_level <= '0;          // LEDs dark
            led1_level <= '0;
            wr_be_q    <= '0;
            panel_a    <= '0;
            panel_b    <= '0;
        end else if (wr_access) begin
            case (offs)
                REG_CTRL:      usb_mode   <= usb_mode_t'(apb.pwdata[1:0]);
                REG_LED0:      led0_level <= apb.pwdata[LED_DEPTH-1:0];
                REG_LED1:      led1_level <= apb.pwdata[LED_DEPTH-1:0];
                REG_USB_WR_BE: wr_be_q    <= apb.pwdata[USB_BE_W-1:0];
                REG_PANEL: begin
                    panel_a <= panel_ch_t'(apb.pwdata[5:0]);
                    panel_b <= panel_ch_t'(apb.pwdata[13:8]);
                end
                default: ;             // Read-only or strobe offsets
            endcase
        end
    end

    // Write payload, qualified by the strobe
    always_ff @(posedge clk) begin
        if (wr_access && (offs == REG_USB_WR_DATA))
            wr_data_q <= apb.pwdata;
    end

    // One-cycle push, the cycle after the access
    always_ff @(posedge clk) begin
        if (reset)
            wr_stb_q <= 1'b0;
        else
            wr_stb_q <= wr_access && (offs == REG_USB_WR_DATA);
    end

    assign raw_wr = '{data: wr_data_q, be: wr_be_q, valid: wr_stb_q};

    // Pop in the access cycle itself, data is read back combinationally
    assign raw_rd_en = access && !apb.pwrite && (offs == REG_USB_RD_DATA);

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////

    always_comb begin
        prdata = '0;                   // Other pages and regions
        if (hit) begin
            case (offs)
                REG_CTRL:        prdata[1:0] = usb_mode;
                REG_LED0:        prdata[LED_DEPTH-1:0] = led0_level;
                REG_LED1:        prdata[LED_DEPTH-1:0] = led1_level;
                REG_USB_WR_DATA: prdata[USB_DATA_W-1:0] = wr_data_q;
                REG_USB_WR_BE:   prdata[USB_BE_W-1:0] = wr_be_q;
                REG_STATUS: begin
                    prdata[0] = usb_wr_full;
                    prdata[1] = usb_rd.empty;
                end
                REG_USB_RD_DATA: prdata[USB_DATA_W-1:0] = usb_rd.data;
                REG_PANEL: begin
                    prdata[5:0]  = panel_a;
                    prdata[13:8] = panel_b;
                end
                default: ;
            endcase
        end
    end

endmodule

/* usb_route.sv */
`timescale 1ns/1ps

module usb_route (
    input  r24_pkg::usb_mode_t          usb_mode,
    input  r24_pkg::usb_wr_t            raw_wr,
    input  logic                        raw_rd_en,
    input  logic [r24_pkg::ADC_W-1:0]   adc_a_data,
    input  r24_pkg::usb_rd_t            usb_rd,
    input  logic                        usb_wr_full,
    output r24_pkg::usb_wr_t            usb_wr,
    output logic                        usb_rd_en
);
    import r24_pkg::*;

    //////////////////////////////////////////////////
    // Write channel and read enable per mode
    //////////////////////////////////////////////////

    always_comb begin
        usb_wr    = raw_wr;            // Register-driven unless overridden
        usb_rd_en = raw_rd_en;
        case (usb_mode)
            MODE_IDLE: begin
                usb_wr    = '{data: '0, be: '1, valid: 1'b0}; // Bus parked
                usb_rd_en = 1'b0;
            end
            MODE_ADC: begin
                // One sample per cycle, the FIFO owns overflow
                usb_wr    = '{data: USB_DATA_W'(adc_a_data), be: '1, valid: 1'b1};
                usb_rd_en = 1'b1;
            end
            MODE_LOOP: begin
                usb_wr    = '{data: usb_rd.data, be: usb_rd.be, valid: usb_rd.valid};
                usb_rd_en = !usb_wr_full;  // Full write side stalls the reads
            end
            default: ;                 // MODE_REGS
        endcase
    end

endmodule

/* panel_io_word.sv */
`timescale 1ns/1ps

module panel_io_word (
    input  logic                 clk,
    input  logic                 reset,
    input  r24_pkg::panel_ch_t   panel_a,
    input  r24_pkg::panel_ch_t   panel_b,
    input  logic                 adc_a_dor,
    input  logic                 adc_b_dor,
    output r24_pkg::panel_word_t panel_word
);
    import r24_pkg::*;

    localparam logic LED_COM = 1'b0;  // Common of the RGB LEDs

    panel_word_t word_d;

    // Expander layout, LEDs active low
    function automatic panel_word_t pack_word(
        input panel_ch_t a,
        input panel_ch_t b,
        input logic      dor_a,
        input logic      dor_b
    );
        panel_word_t w;
        // Red forced on overrange, green and blue suppressed
        w.port1 = {LED_COM,
                   !(a.led[2] || dor_a),
                   !(b.led[2] || dor_b),
                   LED_COM,
                   !(b.led[1] && !dor_b),
                   !(b.led[0] && !dor_b),
                   !(a.led[1] && !dor_a),
                   !(a.led[0] && !dor_a)};
        w.port0 = {1'b0, a.amp_en, !a.att[1], !a.att[0],
                   1'b0, b.amp_en, !b.att[1], !b.att[0]};
        return w;
    endfunction

    assign word_d = pack_word(panel_a, panel_b, adc_a_dor, adc_b_dor);

    always_ff @(posedge clk) begin
        if (reset)
            panel_word <= pack_word('0, '0, 1'b0, 1'b0); // All settings off
        else
            panel_word <= word_d;
    end

endmodule

/* led_ddac.sv */
`timescale 1ns/1ps

module led_ddac #(
    parameter int DEPTH = r24_pkg::LED_DEPTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [DEPTH-1:0] level,  // Brightness, 0 is off
    output logic             out
);

    logic [DEPTH-1:0] acc;
    logic [DEPTH:0]   sum;           // Carry in the top bit

    // First-order delta-sigma, carry density equals level / 2^DEPTH
    assign sum = {1'b0, acc} + {1'b0, level};

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
            out <= 1'b0;
        end else begin
            acc <= sum[DEPTH-1:0];
            out <= sum[DEPTH];       // Registered carry drives the pin
        end
    end

endmodule

/* r24_pkg.sv */
package r24_pkg;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    localparam int ADDR_W = 32;                     // APB address width
    localparam int DATA_W = 32;                     // APB data width
    localparam int OFFS_W = 12;                     // Offset field inside a region

    localparam logic [15:0] APB_BASE_PAGE = 16'h43C0; // paddr[31:16]
    localparam logic [3:0]  REGION_REGS   = 4'h4;     // paddr[15:12]

    // Register offsets within the region
    localparam logic [OFFS_W-1:0] REG_CTRL        = 12'h000; // USB mode
    localparam logic [OFFS_W-1:0] REG_LED0        = 12'h004; // LED0 brightness
    localparam logic [OFFS_W-1:0] REG_LED1        = 12'h008; // LED1 brightness
    localparam logic [OFFS_W-1:0] REG_USB_WR_DATA = 12'h00C; // Write fires the strobe
    localparam logic [OFFS_W-1:0] REG_USB_WR_BE   = 12'h010;
    localparam logic [OFFS_W-1:0] REG_STATUS      = 12'h014; // Read only
    localparam logic [OFFS_W-1:0] REG_USB_RD_DATA = 12'h018; // Read pops the FIFO
    localparam logic [OFFS_W-1:0] REG_PANEL       = 12'h01C; // Channel A/B front panel

    //////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////

    localparam int USB_DATA_W = 32;  // FT601 bus
    localparam int USB_BE_W   = 4;
    localparam int ADC_W      = 8;   // MAX19506 sample
    localparam int LED_DEPTH  = 16;  // Brightness resolution

    // USB write channel source
    typedef enum logic [1:0] {
        MODE_REGS = 2'd0,  // Driven from APB
        MODE_IDLE = 2'd1,
        MODE_ADC  = 2'd2,  // Stream ADC A samples
        MODE_LOOP = 2'd3   // Read side back to write side
    } usb_mode_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [USB_DATA_W-1:0] data;
        logic [USB_BE_W-1:0]   be;
        logic                  valid;  // Push into the write FIFO
    } usb_wr_t;

    typedef struct packed {
        logic [USB_DATA_W-1:0] data;
        logic [USB_BE_W-1:0]   be;
        logic                  valid;  // Data present this cycle
        logic                  empty;  // Read FIFO empty
    } usb_rd_t;

    // One analog channel of the front panel
    typedef struct packed {
        logic [1:0] att;     // Attenuator select
        logic       amp_en;
        logic [2:0] led;     // Red, green, blue
    } panel_ch_t;

    typedef struct packed {
        logic [7:0] port1;   // LEDs
        logic [7:0] port0;   // Attenuators and amps
    } panel_word_t;

endpackage
